/* common/ls_pkg.sv */
// Shared widths, types and opcode fields for the load/store slice; the RAM covers 1 KiB only
package ls_pkg;

  // Bus and datapath widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int BYTE_W    = 8;
  localparam int BYTE_LANES = DATA_W / BYTE_W;

  // Register file geometry
  localparam int REG_SEL_W     = 4;
  localparam int PTR_SEL_W     = 3;
  localparam int NUM_DATA_REGS = 2 ** REG_SEL_W;
  localparam int NUM_PTRS      = 2 ** PTR_SEL_W;

  // Opcode width and the width of its offset field
  localparam int OP_W  = 15;
  localparam int OFS_W = 5;

  // Local data RAM, word addressed, so local addresses alias every 1 KiB
  localparam int RAM_AW    = 8;
  localparam int RAM_DEPTH = 2 ** RAM_AW;

  // Opcode field positions
  // Store when set, load when clear
  localparam int OP_STORE   = 14;
  // Pointer write-back mode (post-increment or pre-decrement)
  localparam int OP_PTR_UPD = 13;
  // Access size bits, neither set means byte
  localparam int OP_WORD    = 12;
  localparam int OP_HALF    = 11;
  // Offset field, scaled by the access size
  localparam int OP_OFS_HI  = 10;
  localparam int OP_OFS_LO  = 6;
  // Pointer register select
  localparam int OP_PTR_HI  = 5;
  localparam int OP_PTR_LO  = 3;
  // Low bits of the data register select
  localparam int OP_REG_HI  = 2;
  localparam int OP_REG_LO  = 0;

  // Bus or pointer address
  typedef logic [ADDR_W-1:0]     addr_t;
  // Data word
  typedef logic [DATA_W-1:0]     word_t;
  // One write enable per byte lane
  typedef logic [BYTE_LANES-1:0] mask_t;
  // Data register index
  typedef logic [REG_SEL_W-1:0]  reg_sel_t;
  // Pointer register index
  typedef logic [PTR_SEL_W-1:0]  ptr_sel_t;
  // Load/store opcode
  typedef logic [OP_W-1:0]       ls_op_t;

endpackage

/* ls_unit/ls_load_align.sv */
// Load data capture and lane extraction; size and offset must be held for the result cycle
`timescale 1ns/1ns

module ls_load_align
  import ls_pkg::*;
(
  input  logic       CLK,
  input  logic       capture,
  input  logic       size_word,
  input  logic       size_half,
  input  logic [1:0] byte_ofs,
  input  word_t      din,
  output word_t      data
);

  // Word captured from the bus the cycle after the RAM read
  word_t rd_word;

  // Capture only when a local load is in its data stage
  always_ff @(posedge CLK)
  begin
    if (capture)
      rd_word <= din;
  end

  // Pick the addressed lane and zero-extend it
  always_comb
  begin
    if (size_word)
      data = rd_word;
    else if (size_half)
      // Bit 1 of the offset picks the upper or lower halfword
      data = {{(DATA_W - 2 * BYTE_W){1'b0}}, rd_word[2 * BYTE_W * byte_ofs[1] +: 2 * BYTE_W]};
    else
      // Byte access, the full offset picks the lane
      data = {{(DATA_W - BYTE_W){1'b0}}, rd_word[BYTE_W * byte_ofs +: BYTE_W]};
  end

endmodule

/* ls_unit/ls_unit.sv */
// No-wait load/store unit; op_vld and dir_vld are exclusive, no hazard interlock, remote loads never return
`timescale 1ns/1ns

module ls_unit
  import ls_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     op_vld,
  input  ls_op_t   op,
  input  logic     dir_vld,
  input  logic     dir_store,
  input  reg_sel_t dir_sel,
  input  addr_t    dir_addr,
  output ptr_sel_t ptr_sel,
  input  addr_t    ptr,
  output reg_sel_t store_sel,
  input  word_t    store_data,
  output addr_t    daddr,
  output logic     dcs,
  output logic     rcn_cs,
  output logic     dwr,
  output mask_t    dmask,
  output word_t    dout,
  input  word_t    din,
  output logic     ptr_upd_vld,
  output ptr_sel_t ptr_upd_sel,
  output addr_t    ptr_upd,
  output logic     load_vld,
  output reg_sel_t load_sel,
  output word_t    load_data
);

  // One entry per load in flight
  typedef struct packed {
    logic       vld;
    logic       word;
    logic       half;
    logic [1:0] ofs;
    reg_sel_t   sel;
  } ld_trk_t;

  logic             req_vld;
  logic             wr_en;
  logic             rcn_space;
  logic             upd_mode;
  logic             acc_word;
  logic             acc_half;
  reg_sel_t         data_reg;
  logic [OFS_W-1:0] ofs;
  addr_t            ofs_scaled;
  addr_t            adj;
  addr_t            ptr_next;
  addr_t            addr_out;
  word_t            wr_data;
  mask_t            data_mask;
  ld_trk_t          trk_in;
  ld_trk_t          trk_d1;
  ld_trk_t          trk_d2;
  ld_trk_t          trk_d3;

  assign req_vld  = op_vld | dir_vld;
  assign upd_mode = op[OP_PTR_UPD];
  assign ofs      = op[OP_OFS_HI:OP_OFS_LO];

  // Direct requests are always word sized
  assign acc_word = dir_vld | op[OP_WORD];
  assign acc_half = !dir_vld & op[OP_HALF];

  // Registers 8..15 are only reachable by opcode with both size bits set
  assign data_reg  = dir_vld ? dir_sel : {op[OP_WORD] & op[OP_HALF], op[OP_REG_HI:OP_REG_LO]};
  assign ptr_sel   = op[OP_PTR_HI:OP_PTR_LO];
  assign store_sel = data_reg;

  // Plain offset is unsigned, the update adjustment is sign-extended
  always_comb
  begin
    if (op[OP_WORD])
    begin
      ofs_scaled = {{(ADDR_W - OFS_W - 2){1'b0}}, ofs, 2'b00};
      adj        = {{(ADDR_W - OFS_W - 2){ofs[OFS_W-1]}}, ofs, 2'b00};
    end
    else if (op[OP_HALF])
    begin
      ofs_scaled = {{(ADDR_W - OFS_W - 1){1'b0}}, ofs, 1'b0};
      adj        = {{(ADDR_W - OFS_W - 1){ofs[OFS_W-1]}}, ofs, 1'b0};
    end
    else
    begin
      ofs_scaled = {{(ADDR_W - OFS_W){1'b0}}, ofs};
      adj        = {{(ADDR_W - OFS_W){ofs[OFS_W-1]}}, ofs};
    end
  end

  assign ptr_next = ptr + (upd_mode ? adj : ofs_scaled);

  // Post-increment uses the old pointer, pre-decrement the new one
  assign addr_out = dir_vld ? dir_addr :
                    (upd_mode && !adj[ADDR_W-1]) ? ptr : ptr_next;

  // Top address bit steers the request to the remote bus
  assign rcn_space = addr_out[ADDR_W-1];
  assign wr_en     = (dir_vld & dir_store) | (op_vld & op[OP_STORE]);

  // Store data goes out on every lane, the mask picks the lanes written
  always_comb
  begin
    if (acc_word)
    begin
      wr_data   = store_data;
      data_mask = '1;
    end
    else if (acc_half)
    begin
      wr_data   = {2{store_data[2*BYTE_W-1:0]}};
      data_mask = addr_out[1] ? 4'b1100 : 4'b0011;
    end
    else
    begin
      wr_data   = {BYTE_LANES{store_data[BYTE_W-1:0]}};
      data_mask = mask_t'(1) << addr_out[1:0];
    end
  end

  // Bus strobes and pointer update valid
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      dcs         <= 1'b0;
      rcn_cs      <= 1'b0;
      dwr         <= 1'b0;
      ptr_upd_vld <= 1'b0;
    end
    else
    begin
      dcs         <= req_vld & !rcn_space;
      rcn_cs      <= req_vld & rcn_space;
      dwr         <= req_vld & wr_en;
      ptr_upd_vld <= op_vld & upd_mode;
    end
  end

  // Request payload, only meaningful alongside a strobe
  always_ff @(posedge CLK)
  begin
    if (req_vld)
    begin
      daddr <= {addr_out[ADDR_W-1:2], 2'b00};
      dmask <= data_mask;
      dout  <= wr_data;
    end
    if (op_vld)
    begin
      ptr_upd_sel <= ptr_sel;
      ptr_upd     <= ptr_next;
    end
  end

  // Only local loads enter the tracking pipeline
  always_comb
  begin
    trk_in      = '0;
    trk_in.vld  = req_vld & !wr_en & !rcn_space;
    trk_in.word = acc_word;
    trk_in.half = acc_half;
    trk_in.ofs  = addr_out[1:0];
    trk_in.sel  = data_reg;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      trk_d1 <= '0;
      trk_d2 <= '0;
      trk_d3 <= '0;
    end
    else
    begin
      trk_d1 <= trk_in;
      trk_d2 <= trk_d1;
      trk_d3 <= trk_d2;
    end
  end

  // Stage two lines up with RAM read data, stage three with the aligned result
  ls_load_align ls_load_align_i (
    .CLK       (CLK),
    .capture   (trk_d2.vld),
    .size_word (trk_d3.word),
    .size_half (trk_d3.half),
    .byte_ofs  (trk_d3.ofs),
    .din       (din),
    .data      (load_data)
  );

  assign load_vld = trk_d3.vld;
  assign load_sel = trk_d3.sel;

  // The two request sources share the decode path and must never overlap
  assert property (@(posedge CLK) disable iff (RST) !(op_vld && dir_vld))
    else $error("opcode and direct request issued in the same cycle");

endmodule

/* logic/reg_file.sv */
// Data and pointer registers with one write port per bank; host writes lose to internal writes
`timescale 1ns/1ns

module reg_file
  import ls_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  ptr_sel_t ptr_sel,
  input  reg_sel_t store_sel,
  input  logic     ptr_upd_vld,
  input  ptr_sel_t ptr_upd_sel,
  input  addr_t    ptr_upd,
  input  logic     load_vld,
  input  reg_sel_t load_sel,
  input  word_t    load_data,
  input  logic     host_wr_vld,
  input  logic     host_wr_ptr,
  input  reg_sel_t host_wr_sel,
  input  word_t    host_wr_data,
  output addr_t    ptr,
  output word_t    store_data
);

  word_t    data_regs [NUM_DATA_REGS];
  addr_t    ptr_regs  [NUM_PTRS];
  logic     host_data_wr;
  logic     host_ptr_wr;
  ptr_sel_t host_ptr_sel;

  assign host_data_wr = host_wr_vld & !host_wr_ptr;
  assign host_ptr_wr  = host_wr_vld & host_wr_ptr;

  // Pointer bank only needs the low select bits
  assign host_ptr_sel = host_wr_sel[PTR_SEL_W-1:0];

  // Data bank, load write-back first
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < NUM_DATA_REGS; i++)
        data_regs[i] <= '0;
    end
    else if (load_vld)
      data_regs[load_sel] <= load_data;
    else if (host_data_wr)
      data_regs[host_wr_sel] <= host_wr_data;
  end

  // Pointer bank, pointer update first
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < NUM_PTRS; i++)
        ptr_regs[i] <= '0;
    end
    else if (ptr_upd_vld)
      ptr_regs[ptr_upd_sel] <= ptr_upd;
    else if (host_ptr_wr)
      ptr_regs[host_ptr_sel] <= host_wr_data;
  end

  // Reads are combinational so the unit sees them in the request cycle
  assign ptr        = ptr_regs[ptr_sel];
  assign store_data = data_regs[store_sel];

  // A dropped host write would silently lose a preload
  assert property (@(posedge CLK) disable iff (RST)
    !((host_data_wr && load_vld) || (host_ptr_wr && ptr_upd_vld)))
    else $error("host write collides with an internal register write");

endmodule

/* logic/data_ram.sv */
// Single-cycle word RAM with byte-lane writes; only RAM_AW+1..2 of the address decode, contents not reset
`timescale 1ns/1ns

module data_ram
  import ls_pkg::*;
(
  input  logic  CLK,
  input  logic  cs,
  input  logic  wr,
  input  addr_t addr,
  input  mask_t mask,
  input  word_t wdata,
  output word_t rdata
);

  word_t             mem [RAM_DEPTH];
  logic [RAM_AW-1:0] word_addr;

  // Byte address to word index, higher bits alias
  assign word_addr = addr[RAM_AW+1:2];

  // Write the enabled lanes, or register the word for a read
  always_ff @(posedge CLK)
  begin
    if (cs && wr)
    begin
      for (int i = 0; i < BYTE_LANES; i++)
      begin
        if (mask[i])
          mem[word_addr][BYTE_W*i +: BYTE_W] <= wdata[BYTE_W*i +: BYTE_W];
      end
    end
    if (cs && !wr)
      rdata <= mem[word_addr];
  end

  // Remote-space addresses must have been routed to the remote bus upstream
  assert property (@(posedge CLK) !(cs && addr[ADDR_W-1]))
    else $error("local RAM selected with a remote-space address");

endmodule

/* logic/ls_top.sv */
// Load/store slice top; remote requests leave on the rcn port and never write back
`timescale 1ns/1ns

module ls_top
  import ls_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     op_vld,
  input  ls_op_t   op,
  input  logic     dir_vld,
  input  logic     dir_store,
  input  reg_sel_t dir_sel,
  input  addr_t    dir_addr,
  input  logic     host_wr_vld,
  input  logic     host_wr_ptr,
  input  reg_sel_t host_wr_sel,
  input  word_t    host_wr_data,
  output logic     rcn_cs,
  output addr_t    rcn_addr,
  output logic     rcn_wr,
  output mask_t    rcn_mask,
  output word_t    rcn_data,
  output logic     ptr_upd_vld,
  output ptr_sel_t ptr_upd_sel,
  output addr_t    ptr_upd,
  output logic     load_vld,
  output reg_sel_t load_sel,
  output word_t    load_data
);

  ptr_sel_t ptr_sel;
  reg_sel_t store_sel;
  addr_t    ptr;
  word_t    store_data;
  addr_t    daddr;
  logic     dcs;
  logic     dwr;
  mask_t    dmask;
  word_t    dout;
  word_t    din;

  // Remote bus shares the request payload with the local bus
  assign rcn_addr = daddr;
  assign rcn_wr   = dwr;
  assign rcn_mask = dmask;
  assign rcn_data = dout;

  ls_unit ls_unit_i (
    .CLK         (CLK),
    .RST         (RST),
    .op_vld      (op_vld),
    .op          (op),
    .dir_vld     (dir_vld),
    .dir_store   (dir_store),
    .dir_sel     (dir_sel),
    .dir_addr    (dir_addr),
    .ptr_sel     (ptr_sel),
    .ptr         (ptr),
    .store_sel   (store_sel),
    .store_data  (store_data),
    .daddr       (daddr),
    .dcs         (dcs),
    .rcn_cs      (rcn_cs),
    .dwr         (dwr),
    .dmask       (dmask),
    .dout        (dout),
    .din         (din),
    .ptr_upd_vld (ptr_upd_vld),
    .ptr_upd_sel (ptr_upd_sel),
    .ptr_upd     (ptr_upd),
    .load_vld    (load_vld),
    .load_sel    (load_sel),
    .load_data   (load_data)
  );

  reg_file reg_file_i (
    .CLK          (CLK),
    .RST          (RST),
    .ptr_sel      (ptr_sel),
    .store_sel    (store_sel),
    .ptr_upd_vld  (ptr_upd_vld),
    .ptr_upd_sel  (ptr_upd_sel),
    .ptr_upd      (ptr_upd),
    .load_vld     (load_vld),
    .load_sel     (load_sel),
    .load_data    (load_data),
    .host_wr_vld  (host_wr_vld),
    .host_wr_ptr  (host_wr_ptr),
    .host_wr_sel  (host_wr_sel),
    .host_wr_data (host_wr_data),
    .ptr          (ptr),
    .store_data   (store_data)
  );

  data_ram data_ram_i (
    .CLK   (CLK),
    .cs    (dcs),
    .wr    (dwr),
    .addr  (daddr),
    .mask  (dmask),
    .wdata (dout),
    .rdata (din)
  );

endmodule

/* verification/tb_ls_tasks.svh */
// Driving, waiting and compare tasks for tb_ls_top; every task starts and ends on a falling edge

// Print the fail message and stop at the first error
task automatic stop_run();
  $display("** FAIL **");
  $fatal(1, "Simulation stopped at the first error");
endtask

// Typed compares, one per kind of result
task automatic check_word(input string what, input word_t exp, input word_t act);
  if (act !== exp)
  begin
    $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
    stop_run();
  end
endtask

task automatic check_addr(input string what, input addr_t exp, input addr_t act);
  if (act !== exp)
  begin
    $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
    stop_run();
  end
endtask

task automatic check_reg_sel(input string what, input reg_sel_t exp, input reg_sel_t act);
  if (act !== exp)
  begin
    $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
    stop_run();
  end
endtask

task automatic check_ptr_sel(input string what, input ptr_sel_t exp, input ptr_sel_t act);
  if (act !== exp)
  begin
    $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
    stop_run();
  end
endtask

task automatic check_mask(input string what, input mask_t exp, input mask_t act);
  if (act !== exp)
  begin
    $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
    stop_run();
  end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
  if (act !== exp)
  begin
    $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
    stop_run();
  end
endtask

// Build an opcode from its fields
function automatic ls_op_t make_op(input logic store, upd, word, half, input logic [4:0] ofs,
                                   input ptr_sel_t p, input logic [2:0] r);
  ls_op_t o;
  o = '0;
  o[OP_STORE] = store;
  o[OP_PTR_UPD] = upd;
  o[OP_WORD] = word;
  o[OP_HALF] = half;
  o[OP_OFS_HI:OP_OFS_LO] = ofs;
  o[OP_PTR_HI:OP_PTR_LO] = p;
  o[OP_REG_HI:OP_REG_LO] = r;
  return o;
endfunction

// One-cycle request drivers
task automatic drive_op(input ls_op_t o);
  op_vld = 1'b1;
  op     = o;
  @(negedge CLK);
  op_vld = 1'b0;
endtask

task automatic drive_direct(input logic store, input reg_sel_t sel, input addr_t addr);
  dir_vld   = 1'b1;
  dir_store = store;
  dir_sel   = sel;
  dir_addr  = addr;
  @(negedge CLK);
  dir_vld   = 1'b0;
endtask

// Preload a data register, or a pointer when is_ptr is set
task automatic host_write(input logic is_ptr, input reg_sel_t sel, input word_t data);
  host_wr_vld  = 1'b1;
  host_wr_ptr  = is_ptr;
  host_wr_sel  = sel;
  host_wr_data = data;
  @(negedge CLK);
  host_wr_vld  = 1'b0;
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(negedge CLK);
endtask

// Wait for the next load result, bounded by 20 cycles
task automatic wait_load(input reg_sel_t exp_sel, input word_t exp_data);
  int n;
  n = 0;
  while (!load_vld && n < 20)
  begin
    @(negedge CLK);
    n++;
  end
  if (!load_vld)
  begin
    $display("Timeout in %s: no load result arrived within 20 cycles", cur_test);
    stop_run();
  end
  check_reg_sel("load_sel", exp_sel, load_sel);
  check_word("load_data", exp_data, load_data);
endtask

// Wait for a pointer write-back, bounded by 20 cycles
task automatic wait_ptr_update(input ptr_sel_t exp_sel, input addr_t exp_ptr);
  int n;
  n = 0;
  while (!ptr_upd_vld && n < 20)
  begin
    @(negedge CLK);
    n++;
  end
  if (!ptr_upd_vld)
  begin
    $display("Timeout in %s: no pointer update arrived within 20 cycles", cur_test);
    stop_run();
  end
  check_ptr_sel("ptr_upd_sel", exp_sel, ptr_upd_sel);
  check_addr("ptr_upd", exp_ptr, ptr_upd);
endtask

// A remote load must never come back, so watch the whole window
task automatic expect_no_load(input int n);
  repeat (n)
  begin
    if (load_vld)
    begin
      $display("Unexpected load result in %s: a remote load wrote back", cur_test);
      stop_run();
    end
    @(negedge CLK);
  end
endtask

/* verification/tb_ls_top.sv */
// Directed testbench for ls_top; stimulus on the falling edge, stops at the first error
`timescale 1ns/1ns

module tb_ls_top
  import ls_pkg::*;
();

  logic     CLK;
  logic     RST;
  logic     op_vld;
  ls_op_t   op;
  logic     dir_vld;
  logic     dir_store;
  reg_sel_t dir_sel;
  addr_t    dir_addr;
  logic     host_wr_vld;
  logic     host_wr_ptr;
  reg_sel_t host_wr_sel;
  word_t    host_wr_data;
  logic     rcn_cs;
  addr_t    rcn_addr;
  logic     rcn_wr;
  mask_t    rcn_mask;
  word_t    rcn_data;
  logic     ptr_upd_vld;
  ptr_sel_t ptr_upd_sel;
  addr_t    ptr_upd;
  logic     load_vld;
  reg_sel_t load_sel;
  word_t    load_data;

  string  cur_test;
  integer seed = 32'h4d5a_56f7;

  ls_top ls_top_i (.*);

  `include "tb_ls_tasks.svh"

  // 8 ns clock
  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Store a register directly, then load it back into a high register
  task automatic direct_word();
    cur_test = "direct_word";
    host_write(1'b0, 4'd5, 32'h1234_5678);
    drive_direct(1'b1, 4'd5, 32'h0000_0040);
    drive_direct(1'b0, 4'd9, 32'h0000_0040);
    wait_load(4'd9, 32'h1234_5678);
    wait_cycles(1);
  endtask

  // Byte and halfword stores and loads at every alignment through pointer 1
  task automatic sub_word_lanes();
    word_t pat;
    cur_test = "sub_word_lanes";
    pat = 32'hCAFE_F00D;
    host_write(1'b1, 4'd1, 32'h0000_0200);
    host_write(1'b0, 4'd0, 32'h0000_0000);
    host_write(1'b0, 4'd1, 32'h1234_56A5);
    host_write(1'b0, 4'd3, pat);
    host_write(1'b0, 4'd4, 32'h7777_BEEF);
    for (int k = 0; k < 4; k++)
    begin
      // Clear the word, store one byte, then read the word and the byte back
      drive_direct(1'b1, 4'd0, 32'h0000_0200);
      drive_op(make_op(1'b1, 1'b0, 1'b0, 1'b0, k[4:0], 3'd1, 3'd1));
      drive_direct(1'b0, 4'd10, 32'h0000_0200);
      wait_load(4'd10, word_t'(8'hA5) << (8 * k));
      wait_cycles(1);
      drive_op(make_op(1'b0, 1'b0, 1'b0, 1'b0, k[4:0], 3'd1, 3'd2));
      wait_load(4'd2, 32'h0000_00A5);
      wait_cycles(1);
    end
    // Full word pattern, then pick lanes out of it
    drive_direct(1'b1, 4'd3, 32'h0000_0200);
    for (int k = 0; k < 4; k++)
    begin
      drive_op(make_op(1'b0, 1'b0, 1'b0, 1'b0, k[4:0], 3'd1, 3'd2));
      wait_load(4'd2, (pat >> (8 * k)) & 32'h0000_00FF);
      wait_cycles(1);
    end
    for (int h = 0; h < 2; h++)
    begin
      drive_op(make_op(1'b0, 1'b0, 1'b0, 1'b1, h[4:0], 3'd1, 3'd2));
      wait_load(4'd2, (pat >> (16 * h)) & 32'h0000_FFFF);
      wait_cycles(1);
    end
    // Halfword store to the upper half takes only the low half of the register
    drive_direct(1'b1, 4'd0, 32'h0000_0200);
    drive_op(make_op(1'b1, 1'b0, 1'b0, 1'b1, 5'd1, 3'd1, 3'd4));
    drive_direct(1'b0, 4'd10, 32'h0000_0200);
    wait_load(4'd10, word_t'(16'hBEEF) << 16);
    wait_cycles(1);
  endtask

  // Plain offset, post-increment and pre-decrement through pointer 2
  task automatic pointer_modes();
    addr_t base;
    cur_test = "pointer_modes";
    base = 32'h0000_0300;
    host_write(1'b1, 4'd2, base);
    host_write(1'b0, 4'd6, 32'h0BAD_F00D);
    host_write(1'b0, 4'd7, 32'h600D_CAFE);
    drive_op(make_op(1'b1, 1'b0, 1'b1, 1'b0, 5'd3, 3'd2, 3'd6));
    check_flag("ptr_upd_vld", 1'b0, ptr_upd_vld);
    drive_direct(1'b0, 4'd11, base + 12);
    wait_load(4'd11, 32'h0BAD_F00D);
    wait_cycles(1);
    // Post-increment writes at the old pointer
    drive_op(make_op(1'b1, 1'b1, 1'b1, 1'b0, 5'd3, 3'd2, 3'd7));
    wait_ptr_update(3'd2, base + 12);
    wait_cycles(2);
    drive_direct(1'b0, 4'd11, base);
    wait_load(4'd11, 32'h600D_CAFE);
    wait_cycles(1);
    // Offset -2 words moves the pointer back by 8 before the access
    drive_op(make_op(1'b1, 1'b1, 1'b1, 1'b0, 5'h1E, 3'd2, 3'd5));
    wait_ptr_update(3'd2, base + 12 - 8);
    wait_cycles(2);
    drive_direct(1'b0, 4'd11, base + 12 - 8);
    wait_load(4'd11, 32'h1234_5678);
    wait_cycles(1);
  endtask

  // Remote-space requests leave on the rcn port and never touch the RAM
  task automatic remote_space();
    cur_test = "remote_space";
    host_write(1'b0, 4'd12, 32'h5555_AAAA);
    drive_direct(1'b1, 4'd12, 32'h0000_0100);
    host_write(1'b0, 4'd13, 32'hDEAD_BEEF);
    drive_direct(1'b1, 4'd13, 32'h8000_0100);
    check_flag("rcn_cs", 1'b1, rcn_cs);
    check_addr("rcn_addr", 32'h8000_0100, rcn_addr);
    check_flag("rcn_wr", 1'b1, rcn_wr);
    check_mask("rcn_mask", 4'b1111, rcn_mask);
    check_word("rcn_data", 32'hDEAD_BEEF, rcn_data);
    drive_direct(1'b0, 4'd14, 32'h8000_0104);
    check_flag("rcn_cs", 1'b1, rcn_cs);
    check_flag("rcn_wr", 1'b0, rcn_wr);
    expect_no_load(20);
    // The aliased local word keeps its value
    drive_direct(1'b0, 4'd14, 32'h0000_0100);
    wait_load(4'd14, 32'h5555_AAAA);
    wait_cycles(1);
  endtask

  // Eight back-to-back word loads into registers 8..15, each result three cycles later
  task automatic pipelined_loads();
    word_t vals [8];
    cur_test = "pipelined_loads";
    host_write(1'b1, 4'd3, 32'h0000_0380);
    for (int k = 0; k < 8; k++)
    begin
      vals[k] = $random(seed);
      host_write(1'b0, reg_sel_t'(k), vals[k]);
      drive_direct(1'b1, reg_sel_t'(k), 32'h0000_0380 + 4 * k);
    end
    wait_cycles(2);
    for (int k = 0; k < 11; k++)
    begin
      if (k < 3)
        check_flag("load_vld", 1'b0, load_vld);
      else
      begin
        check_flag("load_vld", 1'b1, load_vld);
        check_reg_sel("load_sel", reg_sel_t'(8 + k - 3), load_sel);
        check_word("load_data", vals[k-3], load_data);
      end
      // Both size bits set reach the upper register bank with word size
      op_vld = (k < 8);
      if (k < 8)
        op = make_op(1'b0, 1'b0, 1'b1, 1'b1, k[4:0], 3'd3, k[2:0]);
      @(negedge CLK);
    end
    check_flag("load_vld", 1'b0, load_vld);
    wait_cycles(1);
  endtask

  initial
  begin
    op_vld       = 1'b0;
    op           = '0;
    dir_vld      = 1'b0;
    dir_store    = 1'b0;
    dir_sel      = '0;
    dir_addr     = '0;
    host_wr_vld  = 1'b0;
    host_wr_ptr  = 1'b0;
    host_wr_sel  = '0;
    host_wr_data = '0;
    RST          = 1'b1;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    wait_cycles(1);
    direct_word();
    sub_word_lanes();
    pointer_modes();
    remote_space();
    pipelined_loads();
    $display("** PASS **");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verification
common/ls_pkg.sv
ls_unit/ls_load_align.sv
ls_unit/ls_unit.sv
logic/reg_file.sv
logic/data_ram.sv
logic/ls_top.sv
verification/tb_ls_top.sv
